//--- design/controlEncoder.sv
`timescale 1ns/100ps

module controlEncoder
    import controlPkg::*;
(
    input  logic    MOV,
    input  logic    rst,
    input  stateT   nextState,
    output logic    irLoad,
    output logic    pcLoad,
    output logic    npcLoad,
    output logic    rfLoad,
    output logic    marLoad,
    output logic    mdrLoad,
    output logic    memStart,
    output logic    memWrite,
    output logic    memByte,
    output aluOpT   aluOp,
    output srcBSelT srcBSel,
    output logic    regDstRd,
    output logic    carryIn,
    output logic    trap
);

    ctrlWordT ctrlD;
    ctrlWordT ctrlQ;

    // Word for the state the sequencer enters on the next edge
    always_comb begin
        ctrlD = '0; // Strobes low, ALU pass, B from register

        case (nextState)
            fetchAddr: ctrlD.marLoad = 1'b1;
            fetchWait: ctrlD.memStart = 1'b1;
            fetchLoad: begin
                ctrlD.irLoad  = 1'b1;
                ctrlD.pcLoad  = 1'b1;
                ctrlD.npcLoad = 1'b1;
                ctrlD.aluOp   = add;  // PC + 4
                ctrlD.srcBSel = four;
            end
            aluExec: begin
                ctrlD.rfLoad   = 1'b1;
                ctrlD.aluOp    = add;
                ctrlD.srcBSel  = register;
                ctrlD.regDstRd = 1'b1;
                ctrlD.carryIn  = 1'b0; // Unsigned add, no carry in
            end
            storeAddr: begin
                ctrlD.marLoad = 1'b1;
                ctrlD.aluOp   = add;  // Base plus offset
                ctrlD.srcBSel = signExtImm;
            end
            storeData: ctrlD.mdrLoad = 1'b1;
            storeWait: begin
                ctrlD.memStart = 1'b1;
                ctrlD.memWrite = 1'b1;
                ctrlD.memByte  = 1'b1;
            end
            branchCmp: begin
                ctrlD.aluOp   = cmpEq;
                ctrlD.srcBSel = register;
            end
            branchTake: begin
                ctrlD.pcLoad  = 1'b1;
                ctrlD.aluOp   = add;
                ctrlD.srcBSel = shiftedImm;
            end
            controlPkg::trap: ctrlD.trap = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge MOV) begin
        if (rst) begin
            ctrlQ <= '0;
        end else begin
            ctrlQ <= ctrlD;
        end
    end

    assign irLoad   = ctrlQ.irLoad;
    assign pcLoad   = ctrlQ.pcLoad;
    assign npcLoad  = ctrlQ.npcLoad;
    assign rfLoad   = ctrlQ.rfLoad;
    assign marLoad  = ctrlQ.marLoad;
    assign mdrLoad  = ctrlQ.mdrLoad;
    assign memStart = ctrlQ.memStart;
    assign memWrite = ctrlQ.memWrite;
    assign memByte  = ctrlQ.memByte;
    assign aluOp    = ctrlQ.aluOp;
    assign srcBSel  = ctrlQ.srcBSel;
    assign regDstRd = ctrlQ.regDstRd;
    assign carryIn  = ctrlQ.carryIn;
    assign trap     = ctrlQ.trap;

    // A write must always be part of a started access
    writeNeedsStart: assert property (@(posedge MOV) disable iff (rst)
        memWrite |-> memStart)
        else $error("memWrite high without memStart");

endmodule

//--- design/controlPkg.sv
`include "cpuControl_settings.svh"

package controlPkg;

    // Sequencer states
    typedef enum logic [`STATE_WIDTH-1:0] {
        fetchAddr  = 7'd0,
        fetchWait  = 7'd1,
        fetchLoad  = 7'd2,
        decode     = 7'd3,
        aluExec    = 7'd4,
        storeAddr  = 7'd5,
        storeData  = 7'd6,
        storeWait  = 7'd7,
        branchCmp  = 7'd8,
        branchTake = 7'd9,
        trap       = 7'd10
    } stateT;

    typedef enum logic [`ALU_OP_WIDTH-1:0] {
        pass  = 4'b0000,
        add   = 4'b0011,
        sub   = 4'b0100,
        cmpEq = 4'b1111 // Result drives cond back to the sequencer
    } aluOpT;

    // ALU B-input mux
    typedef enum logic [1:0] {
        register   = 2'b00,
        signExtImm = 2'b01,
        shiftedImm = 2'b10,
        four       = 2'b11
    } srcBSelT;

    // One full control word, all zero is the idle word
    typedef struct packed {
        logic    irLoad;
        logic    pcLoad;
        logic    npcLoad;
        logic    rfLoad;
        logic    marLoad;
        logic    mdrLoad;
        logic    memStart;
        logic    memWrite;
        logic    memByte;
        aluOpT   aluOp;
        srcBSelT srcBSel;
        logic    regDstRd;
        logic    carryIn;
        logic    trap;
    } ctrlWordT;

endpackage

//--- design/cpuControl.sv
`timescale 1ns/100ps
`include "cpuControl_settings.svh"

module cpuControl
    import controlPkg::*;
(
    input  logic                    MOV,
    input  logic                    rst,
    input  logic [`INSTR_WIDTH-1:0] ir,
    input  logic                    moc,
    input  logic                    cond,
    output logic                    irLoad,
    output logic                    pcLoad,
    output logic                    npcLoad,
    output logic                    rfLoad,
    output logic                    marLoad,
    output logic                    mdrLoad,
    output logic                    memStart,
    output logic                    memWrite,
    output logic                    memByte,
    output aluOpT                   aluOp,
    output srcBSelT                 srcBSel,
    output logic                    regDstRd,
    output logic                    carryIn,
    output logic                    trap,
    output stateT                   state
);

    stateT nextState; // Encoder registers the word for this state

    decodeIf dec ();

    instructionDecoder decoder (
        .ir  (ir),
        .dec (dec.source)
    );

    stateSequencer sequencer (
        .MOV       (MOV),
        .rst       (rst),
        .moc       (moc),
        .cond      (cond),
        .dec       (dec.sink),
        .state     (state),
        .nextState (nextState)
    );

    controlEncoder encoder (
        .MOV       (MOV),
        .rst       (rst),
        .nextState (nextState),
        .irLoad    (irLoad),
        .pcLoad    (pcLoad),
        .npcLoad   (npcLoad),
        .rfLoad    (rfLoad),
        .marLoad   (marLoad),
        .mdrLoad   (mdrLoad),
        .memStart  (memStart),
        .memWrite  (memWrite),
        .memByte   (memByte),
        .aluOp     (aluOp),
        .srcBSel   (srcBSel),
        .regDstRd  (regDstRd),
        .carryIn   (carryIn),
        .trap      (trap)
    );

endmodule

//--- design/decodeIf.sv
`timescale 1ns/100ps

interface decodeIf
    import isaPkg::*, controlPkg::*;
();

    instrClassT instrClass;
    aluOpT      aluOp;        // Only meaningful for aluReg
    logic       writesReg;
    logic       illegalInstr;

    modport source (
        output instrClass,
        output aluOp,
        output writesReg,
        output illegalInstr
    );

    // Sequencer side, sampled in decode only
    modport sink (
        input instrClass,
        input aluOp,
        input writesReg,
        input illegalInstr
    );

endinterface

//--- design/instructionDecoder.sv
`timescale 1ns/100ps
`include "cpuControl_settings.svh"

module instructionDecoder
    import isaPkg::*, controlPkg::*;
(
    input  logic [`INSTR_WIDTH-1:0] ir,
    decodeIf.source                 dec
);

    opcodeT opcode;
    functT  funct;

    assign opcode = opcodeOf(ir);
    assign funct  = functOf(ir);

    always_comb begin
        logic knownWord;

        // Legal word list, kept apart from the class table below
        knownWord = ((opcode == rType) && (funct == addu))
                  || (opcode == sb)
                  || (opcode == beq);

        dec.instrClass = illegal;
        dec.aluOp      = pass;
        dec.writesReg  = 1'b0;

        case (opcode)
            rType: begin
                if (funct == addu) begin
                    dec.instrClass = aluReg;
                    dec.aluOp      = add;
                    dec.writesReg  = 1'b1; // rd gets the sum
                end
            end
            sb: begin
                dec.instrClass = storeByte;
            end
            beq: begin
                dec.instrClass = branchEq;
            end
            default: begin
                dec.instrClass = illegal;
            end
        endcase

        dec.illegalInstr = !knownWord;
    end

    // The legal list and the class table must agree on every word
    always_comb begin
        decodeAgree: assert final (dec.illegalInstr == (dec.instrClass == illegal))
            else $error("Decoder class and illegal flag disagree for ir %h", ir);
    end

endmodule

//--- design/isaPkg.sv
`include "cpuControl_settings.svh"

package isaPkg;

    // Major opcodes this unit knows about
    typedef enum logic [`OPCODE_WIDTH-1:0] {
        rType = 6'b000000,
        beq   = 6'b000100,
        sb    = 6'b101000
    } opcodeT;

    // R-type function codes
    typedef enum logic [`FUNCT_WIDTH-1:0] {
        addu = 6'b100001
    } functT;

    // What the sequencer needs to know after decode
    typedef enum logic [1:0] {
        aluReg,
        storeByte,
        branchEq,
        illegal
    } instrClassT;

    // Opcode field, unlisted codes kept as raw values
    function automatic opcodeT opcodeOf(input logic [`INSTR_WIDTH-1:0] word);
        opcodeOf = opcodeT'(word[`INSTR_WIDTH-1 -: `OPCODE_WIDTH]);
    endfunction

    // Function field of an R-type word
    function automatic functT functOf(input logic [`INSTR_WIDTH-1:0] word);
        functOf = functT'(word[`FUNCT_WIDTH-1:0]);
    endfunction

endpackage

//--- design/stateSequencer.sv
`timescale 1ns/100ps

module stateSequencer
    import isaPkg::*, controlPkg::*;
(
    input  logic  MOV,
    input  logic  rst,
    input  logic  moc,
    input  logic  cond,
    decodeIf.sink dec,
    output stateT state,
    output stateT nextState
);

    always_ff @(posedge MOV) begin
        if (rst) begin
            state <= fetchAddr;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = fetchAddr;

        case (state)
            fetchAddr: begin
                nextState = fetchWait;
            end
            fetchWait: begin
                nextState = moc ? fetchLoad : fetchWait; // Hold until memory answers
            end
            fetchLoad: begin
                nextState = decode;
            end

            // Decoded fields are only looked at here
            decode: begin
                if (dec.illegalInstr) begin
                    nextState = trap;
                end else begin
                    case (dec.instrClass)
                        aluReg: begin
                            // Only a register-writing add has an execute path
                            if (dec.writesReg && (dec.aluOp == add)) begin
                                nextState = aluExec;
                            end else begin
                                nextState = trap;
                            end
                        end
                        storeByte: nextState = storeAddr;
                        branchEq:  nextState = branchCmp;
                        default:   nextState = trap;
                    endcase
                end
            end

            aluExec: begin
                nextState = fetchAddr;
            end
            storeAddr: begin
                nextState = storeData;
            end
            storeData: begin
                nextState = storeWait;
            end
            storeWait: begin
                nextState = moc ? fetchAddr : storeWait;
            end
            branchCmp: begin
                nextState = cond ? branchTake : fetchAddr; // cond from the cmpEq result
            end
            branchTake: begin
                nextState = fetchAddr;
            end
            trap: begin
                nextState = fetchAddr;
            end
            default: begin
                nextState = fetchAddr;
            end
        endcase
    end

    stateLegal: assert property (@(posedge MOV) disable iff (rst)
        state inside {fetchAddr, fetchWait, fetchLoad, decode, aluExec, storeAddr,
                      storeData, storeWait, branchCmp, branchTake, trap})
        else $error("Sequencer state %0d is not a legal code", state);

    // Memory may only complete an access that was started
    mocInWait: assert property (@(posedge MOV) disable iff (rst)
        moc |-> (state inside {fetchWait, storeWait}))
        else $error("moc seen in state %s", state.name());

    waitLeftOnMoc: assert property (@(posedge MOV) disable iff (rst)
        (($past(state) inside {fetchWait, storeWait}) && (state != $past(state)))
            |-> $past(moc))
        else $error("Wait state left without moc");

endmodule

//--- include/cpuControl_settings.svh
`ifndef CPU_CONTROL_SETTINGS_SVH
`define CPU_CONTROL_SETTINGS_SVH

// Instruction register
`define INSTR_WIDTH 32

// Major opcode sits in the top bits of the word
`define OPCODE_WIDTH 6

// R-type function code sits in the low bits
`define FUNCT_WIDTH 6

// State code as seen on the top-level state port
`define STATE_WIDTH 7

// ALU operation code driven to the datapath
`define ALU_OP_WIDTH 4

`endif

//--- run.sh
#!/usr/bin/env bash
# Build and run the control unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module cpuControlTb \
    -o cpuControlSim > build.log 2>&1 \
    && ./obj_dir/cpuControlSim > sim.log 2>&1 \
    || { echo "Build or simulation stopped early"; cat build.log sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0

//--- test/cpuControlTb.sv
`timescale 1ns/100ps
`include "cpuControl_settings.svh"

module cpuControlTb
    import isaPkg::*, controlPkg::*;
();

    localparam int FETCH_TIMEOUT = 40;  // Cycles allowed between two instruction fetches
    localparam int RANDOM_WORDS  = 160;

    logic MOV, rst, moc, cond, stalled;
    logic [`INSTR_WIDTH-1:0] ir;
    logic irLoad, pcLoad, npcLoad, rfLoad, marLoad, mdrLoad;
    logic memStart, memWrite, memByte, regDstRd, carryIn, trapOut;
    aluOpT   aluOp;
    srcBSelT srcBSel;
    stateT   dutState;

    logic [`INSTR_WIDTH-1:0] progWords[$];
    string      progNames[$];
    string      curName = "reset";
    instrClassT curClass = illegal;
    stateT      expState = fetchAddr;
    ctrlWordT   expWord;
    ctrlWordT   actWord;
    bit running = 0;
    bit afterReset = 1;
    int stateErrors = 0, ctrlErrors = 0, srcBErrors = 0, otherErrors = 0;
    int classSeen[4] = '{0, 0, 0, 0};
    int takenCount = 0, notTakenCount = 0;

    cpuControl uut (
        .MOV(MOV), .rst(rst), .ir(ir), .moc(moc), .cond(cond),
        .irLoad(irLoad), .pcLoad(pcLoad), .npcLoad(npcLoad), .rfLoad(rfLoad),
        .marLoad(marLoad), .mdrLoad(mdrLoad), .memStart(memStart),
        .memWrite(memWrite), .memByte(memByte), .aluOp(aluOp), .srcBSel(srcBSel),
        .regDstRd(regDstRd), .carryIn(carryIn), .trap(trapOut), .state(dutState)
    );

    memoryResponder memory (
        .MOV(MOV), .rst(rst), .memStart(memStart), .moc(moc), .stalled(stalled)
    );

    initial begin
        MOV = 1'b0;
        forever #10 MOV = ~MOV;
    end

    // Instruction class straight from the opcode and funct fields
    function automatic instrClassT classifyWord(input logic [`INSTR_WIDTH-1:0] w);
        if (w[`INSTR_WIDTH-1 -: 6] == rType) begin
            return (w[5:0] == addu) ? aluReg : illegal;
        end else if (w[`INSTR_WIDTH-1 -: 6] == sb) begin
            return storeByte;
        end else if (w[`INSTR_WIDTH-1 -: 6] == beq) begin
            return branchEq;
        end
        return illegal;
    endfunction

    // Word kind 0 ADDU, 1 SB, 2 BEQ, 3 bad funct, 4 unlisted opcode, 5 any word
    function automatic logic [`INSTR_WIDTH-1:0] makeWord(input int kind);
        logic [`INSTR_WIDTH-1:0] w;
        w = $urandom;
        case (kind)
            0: begin
                w[`INSTR_WIDTH-1 -: 6] = rType;
                w[5:0] = addu;
            end
            1: w[`INSTR_WIDTH-1 -: 6] = sb;
            2: w[`INSTR_WIDTH-1 -: 6] = beq;
            3: begin
                w[`INSTR_WIDTH-1 -: 6] = rType;
                if (w[5:0] == addu) w[5:0] = 6'b100000;
            end
            4: begin
                if (w[`INSTR_WIDTH-1 -: 6] inside {rType, sb, beq}) begin
                    w[`INSTR_WIDTH-1 -: 6] = 6'b111111;
                end
            end
            default: ;
        endcase
        return w;
    endfunction

    task automatic addWord(input int kind);
        string names[6] = '{"ADDU", "SB", "BEQ", "illegal funct", "illegal opcode", "random"};
        progWords.push_back(makeWord(kind));
        progNames.push_back(names[kind]);
    endtask

    // Control word expected in each state
    function automatic ctrlWordT expectedCtrl(input stateT s);
        ctrlWordT c;
        c = '0;
        case (s)
            fetchAddr: c.marLoad = 1'b1;
            fetchWait: c.memStart = 1'b1;
            fetchLoad: begin
                c.irLoad  = 1'b1;
                c.pcLoad  = 1'b1;
                c.npcLoad = 1'b1;
                c.aluOp   = add;
                c.srcBSel = four;
            end
            aluExec: begin
                c.rfLoad   = 1'b1;
                c.aluOp    = add;
                c.srcBSel  = register;
                c.regDstRd = 1'b1;
            end
            storeAddr: begin
                c.marLoad = 1'b1;
                c.aluOp   = add;
                c.srcBSel = signExtImm;
            end
            storeData: c.mdrLoad = 1'b1;
            storeWait: begin
                c.memStart = 1'b1;
                c.memWrite = 1'b1;
                c.memByte  = 1'b1;
            end
            branchCmp: c.aluOp = cmpEq;
            branchTake: begin
                c.pcLoad  = 1'b1;
                c.aluOp   = add;
                c.srcBSel = shiftedImm;
            end
            trap: c.trap = 1'b1;
            default: ;
        endcase
        return c;
    endfunction

    task automatic checkState(input string name, input stateT expected, input stateT actual);
        if (actual !== expected) begin
            stateErrors++;
            $display("ERROR %s: state expected %s, actual %s (%0d) at %0t", name,
                     expected.name(), actual.name(), actual, $time);
        end
    endtask

    // Strobes and aluOp only
    task automatic checkControl(input string name, input ctrlWordT expected,
                                input ctrlWordT actual);
        ctrlWordT e;
        ctrlWordT a;
        e = expected;
        a = actual;
        e.srcBSel = register;
        a.srcBSel = register;
        if (a !== e) begin
            ctrlErrors++;
            $display("ERROR %s: control expected %h aluOp %s, actual %h aluOp %s at %0t",
                     name, e, e.aluOp.name(), a, a.aluOp.name(), $time);
        end
    endtask

    task automatic checkSrcB(input string name, input srcBSelT expected, input srcBSelT actual);
        if (actual !== expected) begin
            srcBErrors++;
            $display("ERROR %s: srcBSel expected %s, actual %s at %0t", name,
                     expected.name(), actual.name(), $time);
        end
    endtask

    // Compare mid-cycle and step the reference state
    always @(negedge MOV) begin
        if (running) begin
            expWord = afterReset ? ctrlWordT'('0) : expectedCtrl(expState);
            actWord = '{irLoad, pcLoad, npcLoad, rfLoad, marLoad, mdrLoad, memStart, memWrite,
                        memByte, aluOp, srcBSel, regDstRd, carryIn, trapOut};
            checkState(curName, expState, dutState);
            checkControl(curName, expWord, actWord);
            checkSrcB(curName, expWord.srcBSel, actWord.srcBSel);
            if (memWrite && !memStart) begin
                otherErrors++;
                $display("memWrite was high without memStart at %0t", $time);
            end
            // Execute path the DUT actually took for each class
            case (dutState)
                aluExec:   classSeen[0]++;
                storeAddr: classSeen[1]++;
                branchCmp: classSeen[2]++;
                trap:      classSeen[3]++;
                default: ;
            endcase
            afterReset = 0;
            case (expState)
                fetchAddr: expState = fetchWait;
                fetchWait: if (moc) expState = fetchLoad;
                fetchLoad: expState = decode;
                decode: begin
                    case (curClass)
                        aluReg:    expState = aluExec;
                        storeByte: expState = storeAddr;
                        branchEq:  expState = branchCmp;
                        default:   expState = trap;
                    endcase
                end
                storeAddr: expState = storeData;
                storeData: expState = storeWait;
                storeWait: if (moc) expState = fetchAddr;
                branchCmp: begin
                    if (cond) begin
                        takenCount++;
                        expState = branchTake;
                    end else begin
                        notTakenCount++;
                        expState = fetchAddr;
                    end
                end
                default: expState = fetchAddr; // aluExec, branchTake and trap
            endcase
        end
    end

    initial begin
        int  nextWord;
        int  idle;
        bit  sawLoad;
        bit  finished;
        void'($urandom(32'hdcb0_695e));
        rst      = 1'b1;
        ir       = '0;
        cond     = 1'b0;
        nextWord = 0;
        idle     = 0;
        finished = 0;
        for (int k = 0; k < 5; k++) addWord(k);
        addWord(2); // Second branch for the other cond value
        for (int k = 0; k < RANDOM_WORDS; k++) addWord(int'($urandom_range(5, 0)));

        repeat (16) @(posedge MOV);
        #2;
        rst     = 1'b0;
        running = 1;

        while (!finished && idle < FETCH_TIMEOUT) begin
            @(negedge MOV);
            sawLoad = irLoad;
            @(posedge MOV);
            #2;
            cond = 1'($urandom);
            if (sawLoad) begin
                idle = 0;
                if (nextWord < progWords.size()) begin
                    ir       = progWords[nextWord];
                    curClass = classifyWord(ir);
                    curName  = progNames[nextWord];
                    nextWord++;
                end else begin
                    finished = 1;
                end
            end else begin
                idle++;
            end
        end
        running = 0;

        if (!finished) begin
            otherErrors++;
            $display("No instruction fetch for %0d cycles, the control unit is stuck", idle);
        end
        if (stalled) begin
            otherErrors++;
            $display("Memory stand-in saw no access for too long");
        end
        if (classSeen[0] == 0 || classSeen[1] == 0 || classSeen[2] == 0 || classSeen[3] == 0) begin
            otherErrors++;
            $display("Not every instruction class reached its execute state");
        end
        if (takenCount == 0 || notTakenCount == 0) begin
            otherErrors++;
            $display("Branch was not seen both taken and not taken");
        end

        $display("Errors: state %0d, control %0d, srcB %0d, other %0d", stateErrors,
                 ctrlErrors, srcBErrors, otherErrors);
        if (stateErrors + ctrlErrors + srcBErrors + otherErrors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- test/memoryResponder.sv
`timescale 1ns/100ps

module memoryResponder (
    input  logic MOV,
    input  logic rst,
    input  logic memStart,
    output logic moc,
    output logic stalled
);

    localparam int IDLE_LIMIT = 20; // Accesses are never more than a few cycles apart

    int delay;
    int idle;

    initial begin
        moc     = 1'b0;
        stalled = 1'b0;
        idle    = 0;
        forever begin
            @(posedge MOV);
            #2;
            if (rst) begin
                idle = 0;
            end else if (memStart) begin
                delay = $urandom_range(4, 1);
                for (int i = 1; i < delay; i++) begin
                    @(posedge MOV);
                    #2;
                end
                moc = 1'b1; // Sampled on the next edge
                @(posedge MOV);
                #2;
                moc  = 1'b0;
                idle = 0;
            end else begin
                idle++;
                if (idle > IDLE_LIMIT) begin
                    stalled = 1'b1; // No access started for too long
                end
            end
        end
    end

endmodule

//--- vlog.f
+incdir+include
design/isaPkg.sv
design/controlPkg.sv
design/decodeIf.sv
design/instructionDecoder.sv
design/stateSequencer.sv
design/controlEncoder.sv
design/cpuControl.sv
test/memoryResponder.sv
test/cpuControlTb.sv
